/* project.f */
+incdir+include
hdl/sdp_pkg.sv
hdl/sd_clock_gen.sv
hdl/sinc3_decimator.sv
hdl/fault_comparators.sv
hdl/sample_combiner.sv
hdl/sdp_registers.sv
hdl/sigma_delta_processor.sv
test/sdp_checker.sv
test/sdp_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = sdp_tb
FILELIST  = project.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/sdp_tb.sv */
/*
 Testbench for the sigma-delta front end
 Clock, reset, phased random stimulus, sinc3 and fault model, checks
*/
`include "sdp_macros.svh"

module sdp_tb import sdp_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_CH         = `SDP_N_CHANNELS;
    localparam int MAIN_R       = `SDP_MAIN_RATIO;
    localparam int CMP_R        = `SDP_CMP_RATIO;
    localparam int PHASE_CYCLES = 1000;
    localparam int NUM_PHASES   = 5;
    localparam int RESET_CYCLES = 4;
    localparam int TIMEOUT      = (NUM_PHASES * PHASE_CYCLES + RESET_CYCLES) * 3 / 2;
    localparam longint SAT_MAX  = (longint'(1) << (`SDP_SAMPLE_W - 1)) - 1;
    localparam longint SAT_MIN  = -(longint'(1) << (`SDP_SAMPLE_W - 1));

    logic               clock;
    logic               rst;
    logic [N_CH-1:0]    data_in;
    logic               sync;
    reg_write_t         reg_wr;
    logic               clock_out;
    sample_t            data_out;
    logic               data_valid;
    channel_mask_t      channel_faults;
    logic               combined_fault;

    // Model state, index 0 is the main filter and 1 the comparator filter
    longint integ1 [2][N_CH];
    longint integ2 [2][N_CH];
    longint integ3 [2][N_CH];
    longint integ3_d [2][N_CH];
    longint comb1_d [2][N_CH];
    longint comb2_d [2][N_CH];
    longint low_thr [N_CH];
    longint high_thr [N_CH];
    longint offs [N_CH];
    longint cmp_sample [N_CH];
    sample_t exp_sample [$];
    longint exp_cycle [$];
    channel_mask_t exp_faults;
    logic exp_combined;
    longint cycle;
    int phase;
    int m_cnt;
    int c_cnt;
    bit prev_co;
    bit prev_dv;
    bit cmp_pending;
    bit sync_armed;
    int sync_rises;
    longint group_due;
    int samples_checked;
    int fault_points;
    int cycles_run;

    sigma_delta_processor sigma_delta_processor_inst (
        .clock          (clock),
        .rst            (rst),
        .data_in        (data_in),
        .sync           (sync),
        .reg_wr         (reg_wr),
        .clock_out      (clock_out),
        .data_out       (data_out),
        .data_valid     (data_valid),
        .channel_faults (channel_faults),
        .combined_fault (combined_fault)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reporting helpers

    task automatic stop_with_failure();
        $display("Test failed");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input longint got, input longint expected);
        assert (got == expected) else begin
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, name, got, expected);
            stop_with_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Filter model

    // Centering around R^3/2, offset removal, 16-bit saturation
    function automatic longint centered_value(input longint raw, input longint r,
                                              input longint offset);
        longint v;
        v = raw - (r * r * r) / 2 - offset;
        if (v > SAT_MAX) begin
            v = SAT_MAX;
        end else if (v < SAT_MIN) begin
            v = SAT_MIN;
        end
        return v;
    endfunction

    // One input bit through a model filter, combs first at a decimation point
    task automatic filter_step(input int f, input int ch, input bit dec, input bit b,
                               input longint offset, output longint result);
        longint c1;
        longint c2;
        longint c3;
        longint r;
        int w;
        r = (f == 0) ? longint'(MAIN_R) : longint'(CMP_R);
        // Filter words are 3 log2(R) + 1 bits wide and wrap
        w = (f == 0) ? 3 * $clog2(MAIN_R) + 1 : 3 * $clog2(CMP_R) + 1;
        result = 0;
        if (dec) begin
            c1 = integ3[f][ch] - integ3_d[f][ch];
            c2 = c1 - comb1_d[f][ch];
            c3 = c2 - comb2_d[f][ch];
            integ3_d[f][ch] = integ3[f][ch];
            comb1_d[f][ch]  = c1;
            comb2_d[f][ch]  = c2;
            result = centered_value(c3 & ((longint'(1) << w) - 1), r, offset);
        end
        // Each stage takes the previous value of the stage before it
        integ3[f][ch] = integ3[f][ch] + integ2[f][ch];
        integ2[f][ch] = integ2[f][ch] + integ1[f][ch];
        integ1[f][ch] = integ1[f][ch] + longint'(b);
    endtask

    task automatic reset_model();
        for (int f = 0; f < 2; f++) begin
            for (int ch = 0; ch < N_CH; ch++) begin
                integ1[f][ch]   = 0;
                integ2[f][ch]   = 0;
                integ3[f][ch]   = 0;
                integ3_d[f][ch] = 0;
                comb1_d[f][ch]  = 0;
                comb2_d[f][ch]  = 0;
            end
        end
        for (int ch = 0; ch < N_CH; ch++) begin
            low_thr[ch]    = 0;
            high_thr[ch]   = 0;
            offs[ch]       = 0;
            cmp_sample[ch] = 0;
        end
        exp_sample.delete();
        exp_cycle.delete();
        exp_faults   = '0;
        exp_combined = 1'b0;
        phase        = 0;
        m_cnt        = 0;
        c_cnt        = 0;
        prev_co      = 1'b0;
        prev_dv      = 1'b0;
        cmp_pending  = 1'b0;
        sync_armed   = 1'b0;
        sync_rises   = 0;
        group_due    = -1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Model and checks, mid-cycle where every signal is settled

    always @(negedge clock) begin : model
        bit rise;
        bit main_dec;
        bit cmp_dec;
        bit exp_valid;
        longint result;
        sample_t s;
        int a;
        // Modulator clock low for two cycles, high for two
        check_value("clock_out", longint'(clock_out), longint'((phase % 4) >= 2));
        check_value("channel_faults", longint'(channel_faults), longint'(exp_faults));
        check_value("combined_fault", longint'(combined_fault), longint'(exp_combined));
        exp_valid = (exp_cycle.size() > 0) && (exp_cycle[0] == cycle);
        check_value("data_valid", longint'(data_valid), longint'(exp_valid));
        if (exp_valid) begin
            s = exp_sample.pop_front();
            void'(exp_cycle.pop_front());
            check_value("data_out.channel", longint'(data_out.channel), longint'(s.channel));
            check_value("data_out.data", longint'($signed(data_out.data)),
                        longint'($signed(s.data)));
            samples_checked++;
        end
        // First group after a sync lands two cycles after its 16th bit
        if (data_valid && !prev_dv && group_due >= 0) begin
            check_value("data_valid start cycle", cycle, group_due);
            group_due = -1;
        end
        prev_dv = data_valid;
        if (rst) begin
            reset_model();
        end else begin
            // Fault flags take the thresholds of the cycle after the comparator point
            if (cmp_pending) begin
                for (int ch = 0; ch < N_CH; ch++) begin
                    exp_faults[ch] = (cmp_sample[ch] > high_thr[ch]) ||
                                     (cmp_sample[ch] < low_thr[ch]);
                end
                exp_combined = |exp_faults;
                cmp_pending  = 1'b0;
                fault_points++;
            end
            rise     = clock_out && !prev_co;
            prev_co  = clock_out;
            main_dec = rise && (m_cnt == MAIN_R - 1);
            cmp_dec  = rise && (c_cnt == CMP_R - 1);
            if (rise) begin
                for (int ch = 0; ch < N_CH; ch++) begin
                    filter_step(0, ch, main_dec, data_in[ch], offs[ch], result);
                    if (main_dec) begin
                        s.channel = CH_W'(ch);
                        s.data    = `SDP_SAMPLE_W'(result);
                        exp_sample.push_back(s);
                        exp_cycle.push_back(cycle + 2 + longint'(ch));
                    end
                    filter_step(1, ch, cmp_dec, data_in[ch], 0, result);
                    if (cmp_dec) begin
                        cmp_sample[ch] = result;
                    end
                end
                cmp_pending = cmp_dec;
            end
            // Sync wins over the main count, the comparator count runs free
            if (sync) begin
                m_cnt      = 0;
                sync_armed = 1'b1;
                sync_rises = 0;
            end else if (main_dec) begin
                m_cnt = 0;
            end else if (rise) begin
                m_cnt++;
            end
            if (cmp_dec) begin
                c_cnt = 0;
            end else if (rise) begin
                c_cnt++;
            end
            if (!sync && rise && sync_armed) begin
                sync_rises++;
                if (sync_rises == MAIN_R) begin
                    group_due  = cycle + 2;
                    sync_armed = 1'b0;
                end
            end
            // Register writes show from the next cycle on
            if (reg_wr.strobe) begin
                a = int'(reg_wr.addr);
                if (a < N_CH) begin
                    low_thr[a] = longint'(reg_wr.data);
                end else if (a < 2 * N_CH) begin
                    high_thr[a - N_CH] = longint'(reg_wr.data);
                end else if (a < 3 * N_CH) begin
                    offs[a - 2 * N_CH] = longint'(reg_wr.data);
                end
            end
            phase++;
        end
        cycle++;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus

    // Mode 1 mapped registers, 2 adds unmapped addresses, 3 large offsets
    function automatic reg_write_t random_write(input int mode);
        reg_write_t w;
        int addr;
        int value;
        if (mode == 3) begin
            addr = 2 * N_CH + int'($urandom_range(0, N_CH - 1));
        end else if (mode == 2 && $urandom_range(0, 2) == 0) begin
            addr = int'($urandom_range(3 * N_CH, (1 << `SDP_REG_ADDR_W) - 1));
        end else begin
            addr = int'($urandom_range(0, 3 * N_CH - 1));
        end
        if (addr < 2 * N_CH) begin
            value = int'($urandom_range(0, 600)) - 300;
        end else if (mode == 3) begin
            value = int'($urandom_range(0, 80000)) - 40000;
        end else begin
            value = int'($urandom_range(0, 4000)) - 2000;
        end
        w.strobe = 1'b1;
        w.addr   = `SDP_REG_ADDR_W'(addr);
        w.data   = value;
        return w;
    endfunction

    // Bit density in percent, register traffic, optional sync pulses
    task automatic run_phase(input int density, input int write_mode, input bit sync_on);
        for (int i = 0; i < PHASE_CYCLES; i++) begin
            @(posedge clock);
            #1;
            for (int ch = 0; ch < N_CH; ch++) begin
                data_in[ch] = (int'($urandom_range(0, 99)) < density);
            end
            sync   = sync_on && (i == 100 || $urandom_range(0, 299) == 0);
            reg_wr = '0;
            if (write_mode != 0 && $urandom_range(0, 15) == 0) begin
                reg_wr = random_write(write_mode);
            end
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Run limit
    always @(posedge clock) begin
        cycles_run++;
        if (cycles_run > TIMEOUT) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
            stop_with_failure();
        end
    end

    initial begin
        rst             = 1'b1;
        data_in         = '0;
        sync            = 1'b0;
        reg_wr          = '0;
        cycle           = 0;
        samples_checked = 0;
        fault_points    = 0;
        cycles_run      = 0;
        void'($urandom(56));
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        rst = 1'b0;
        run_phase(50, 0, 1'b0);
        run_phase(85, 1, 1'b0);
        run_phase(15, 2, 1'b1);
        run_phase(100, 3, 1'b0);
        run_phase(60, 2, 1'b1);
        // Let the last output group drain
        while (exp_cycle.size() != 0) begin
            @(posedge clock);
        end
        if (samples_checked > 0 && fault_points > 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("No output samples or fault updates were observed");
            stop_with_failure();
        end
    end

endmodule

/* test/sdp_checker.sv */
/*
 Concurrent assertions on the sigma-delta front end
 Strobe alignment and output burst length, bound into the top level
*/
`include "sdp_macros.svh"

module sdp_checker (
    input logic clock,
    input logic rst,
    input logic clock_out,
    input logic bit_strobe,
    input logic main_strobe,
    input logic data_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    // Cycles of data_valid seen so far in the current burst
    int run_len;

    // Bit strobes since the last main decimation point, held at the ratio
    int bits_since_main;

    always_ff @(posedge clock) begin
        if (rst) begin
            run_len <= 0;
        end else if (data_valid) begin
            run_len <= run_len + 1;
        end else begin
            run_len <= 0;
        end
    end

    always_ff @(posedge clock) begin
        if (rst || main_strobe) begin
            bits_since_main <= 0;
        end else if (bit_strobe && bits_since_main < `SDP_MAIN_RATIO) begin
            bits_since_main <= bits_since_main + 1;
        end
    end

    // Bits are taken only on the rising modulator clock
    bit_on_rise: assert property (@(posedge clock) disable iff (rst)
        bit_strobe |-> (clock_out && !$past(clock_out)))
        else $error("bit_strobe outside a rising clock_out cycle");

    rise_has_bit: assert property (@(posedge clock) disable iff (rst)
        (clock_out && !$past(clock_out)) |-> bit_strobe)
        else $error("rising clock_out without bit_strobe");

    // A decimation point closes a block of at least a full ratio of bits
    main_on_bit: assert property (@(posedge clock) disable iff (rst)
        main_strobe |-> (bit_strobe && bits_since_main >= `SDP_MAIN_RATIO - 1))
        else $error("main_strobe without bit_strobe or before a full block of bits");

    // One burst carries every channel once
    burst_not_long: assert property (@(posedge clock) disable iff (rst)
        data_valid |-> (run_len < `SDP_N_CHANNELS))
        else $error("data_valid burst longer than the channel count");

    burst_not_short: assert property (@(posedge clock) disable iff (rst)
        (!data_valid && run_len != 0) |-> (run_len == `SDP_N_CHANNELS))
        else $error("data_valid burst shorter than the channel count");

endmodule

bind sigma_delta_processor sdp_checker sdp_checker_inst (
    .clock       (clock),
    .rst         (rst),
    .clock_out   (clock_out),
    .bit_strobe  (bit_strobe),
    .main_strobe (main_strobe),
    .data_valid  (data_valid)
);

/* hdl/sigma_delta_processor.sv */
/*
 Multi-channel sigma-delta acquisition front end, top level
 Clock generator, registers, main and comparator decimators, faults, output
*/
`include "sdp_macros.svh"

module sigma_delta_processor import sdp_pkg::*; (
    input  logic                       clock,
    input  logic                       rst,
    input  logic [`SDP_N_CHANNELS-1:0] data_in,
    input  logic                       sync,
    input  reg_write_t                 reg_wr,
    output logic                       clock_out,
    output sample_t                    data_out,
    output logic                       data_valid,
    output channel_mask_t              channel_faults,
    output logic                       combined_fault
);

    logic bit_strobe;
    logic main_strobe;
    logic cmp_strobe;

    logic signed [REG_DATA_W-1:0]    low_thresholds [`SDP_N_CHANNELS];
    logic signed [REG_DATA_W-1:0]    high_thresholds [`SDP_N_CHANNELS];
    logic signed [REG_DATA_W-1:0]    offsets [`SDP_N_CHANNELS];

    logic signed [`SDP_SAMPLE_W-1:0] main_samples [`SDP_N_CHANNELS];
    logic signed [`SDP_SAMPLE_W-1:0] cmp_samples [`SDP_N_CHANNELS];
    logic [`SDP_N_CHANNELS-1:0]      main_valid;
    logic [`SDP_N_CHANNELS-1:0]      cmp_valid;

    ////////////////////////////////////////////////////////////////////////////
    // Control

    sd_clock_gen sd_clock_gen_inst (
        .clock       (clock),
        .rst         (rst),
        .sync        (sync),
        .clock_out   (clock_out),
        .bit_strobe  (bit_strobe),
        .main_strobe (main_strobe),
        .cmp_strobe  (cmp_strobe)
    );

    sdp_registers sdp_registers_inst (
        .clock           (clock),
        .rst             (rst),
        .reg_wr          (reg_wr),
        .low_thresholds  (low_thresholds),
        .high_thresholds (high_thresholds),
        .offsets         (offsets)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Filters, two decimators per channel

    for (genvar i = 0; i < `SDP_N_CHANNELS; i++) begin : g_channel
        sinc3_decimator #(
            .RATIO (`SDP_MAIN_RATIO)
        ) main_decimator_inst (
            .clock      (clock),
            .rst        (rst),
            .bit_strobe (bit_strobe),
            .dec_strobe (main_strobe),
            .bit_in     (data_in[i]),
            .offset     (offsets[i]),
            .sample     (main_samples[i]),
            .out_valid  (main_valid[i])
        );

        // Comparator path runs uncorrected
        sinc3_decimator #(
            .RATIO (`SDP_CMP_RATIO)
        ) cmp_decimator_inst (
            .clock      (clock),
            .rst        (rst),
            .bit_strobe (bit_strobe),
            .dec_strobe (cmp_strobe),
            .bit_in     (data_in[i]),
            .offset     (32'sd0),
            .sample     (cmp_samples[i]),
            .out_valid  (cmp_valid[i])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // Faults and output stream

    // All channels share the strobes, so valids line up
    fault_comparators fault_comparators_inst (
        .clock           (clock),
        .rst             (rst),
        .samples         (cmp_samples),
        .sample_valid    (&cmp_valid),
        .low_thresholds  (low_thresholds),
        .high_thresholds (high_thresholds),
        .channel_faults  (channel_faults),
        .combined_fault  (combined_fault)
    );

    sample_combiner sample_combiner_inst (
        .clock         (clock),
        .rst           (rst),
        .samples       (main_samples),
        .samples_valid (&main_valid),
        .data_out      (data_out),
        .data_valid    (data_valid)
    );

endmodule

/* hdl/sdp_registers.sv */
/*
 Threshold and offset register file
 Three banks of N words, written by a strobe, no read-back
*/
`include "sdp_macros.svh"

module sdp_registers import sdp_pkg::*; (
    input  logic                         clock,
    input  logic                         rst,
    input  reg_write_t                   reg_wr,
    output logic signed [REG_DATA_W-1:0] low_thresholds [`SDP_N_CHANNELS],
    output logic signed [REG_DATA_W-1:0] high_thresholds [`SDP_N_CHANNELS],
    output logic signed [REG_DATA_W-1:0] offsets [`SDP_N_CHANNELS]
);

    localparam int N = `SDP_N_CHANNELS;

    // Bank base at 0, N and 2N; other addresses fall through
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < N; i++) begin
                low_thresholds[i]  <= '0;
                high_thresholds[i] <= '0;
                offsets[i]         <= '0;
            end
        end else if (reg_wr.strobe) begin
            for (int i = 0; i < N; i++) begin
                if (reg_wr.addr == `SDP_REG_ADDR_W'(i)) begin
                    low_thresholds[i] <= reg_wr.data;
                end
                if (reg_wr.addr == `SDP_REG_ADDR_W'(N + i)) begin
                    high_thresholds[i] <= reg_wr.data;
                end
                if (reg_wr.addr == `SDP_REG_ADDR_W'(2 * N + i)) begin
                    offsets[i] <= reg_wr.data;
                end
            end
        end
    end

endmodule

/* hdl/sample_combiner.sv */
/*
 Output serializer
 Captures all channel samples at once, emits them tagged, one per cycle
*/
`include "sdp_macros.svh"

module sample_combiner import sdp_pkg::*; (
    input  logic                            clock,
    input  logic                            rst,
    input  logic signed [`SDP_SAMPLE_W-1:0] samples [`SDP_N_CHANNELS],
    input  logic                            samples_valid,
    output sample_t                         data_out,
    output logic                            data_valid
);

    logic signed [`SDP_SAMPLE_W-1:0] capture [`SDP_N_CHANNELS];
    logic                            busy;
    logic [CH_W-1:0]                 idx;

    // Snapshot of all channels
    always_ff @(posedge clock) begin
        if (samples_valid) begin
            capture <= samples;
        end
    end

    // Burst control, N cycles starting the cycle after capture
    always_ff @(posedge clock) begin
        if (rst) begin
            busy <= 1'b0;
            idx  <= '0;
        end else if (samples_valid) begin
            busy <= 1'b1;
            idx  <= '0;
        end else if (busy) begin
            if (idx == CH_W'(`SDP_N_CHANNELS - 1)) begin
                busy <= 1'b0;
                idx  <= '0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    // Tag follows the index
    assign data_out.channel = idx;
    assign data_out.data    = capture[idx];
    assign data_valid       = busy;

endmodule

/* hdl/fault_comparators.sv */
/*
 Over-range and under-range fault comparators
 Registered per-channel flags and their OR
*/
`include "sdp_macros.svh"

module fault_comparators import sdp_pkg::*; (
    input  logic                            clock,
    input  logic                            rst,
    input  logic signed [`SDP_SAMPLE_W-1:0] samples [`SDP_N_CHANNELS],
    input  logic                            sample_valid,
    input  logic signed [REG_DATA_W-1:0]    low_thresholds [`SDP_N_CHANNELS],
    input  logic signed [REG_DATA_W-1:0]    high_thresholds [`SDP_N_CHANNELS],
    output channel_mask_t                   channel_faults,
    output logic                            combined_fault
);

    channel_mask_t faults_next;

    // Outside the window on either side
    always_comb begin
        for (int i = 0; i < `SDP_N_CHANNELS; i++) begin
            faults_next[i] = (REG_DATA_W'(samples[i]) > high_thresholds[i]) ||
                             (REG_DATA_W'(samples[i]) < low_thresholds[i]);
        end
    end

    // Flags and their OR move together, once per comparator sample
    always_ff @(posedge clock) begin
        if (rst) begin
            channel_faults <= '0;
            combined_fault <= 1'b0;
        end else if (sample_valid) begin
            channel_faults <= faults_next;
            combined_fault <= |faults_next;
        end
    end

endmodule

/* hdl/sinc3_decimator.sv */
/*
 Third-order CIC (sinc3) decimator for one 1-bit stream
 Centering, offset correction, saturation, output valid
*/
`include "sdp_macros.svh"

module sinc3_decimator #(
    parameter int RATIO = 16
) (
    input  logic                            clock,
    input  logic                            rst,
    input  logic                            bit_strobe,
    input  logic                            dec_strobe,
    input  logic                            bit_in,
    input  logic signed [31:0]              offset,
    output logic signed [`SDP_SAMPLE_W-1:0] sample,
    output logic                            out_valid
);

    // Filter width holds R^3 without overflow
    localparam int W    = 3 * $clog2(RATIO) + 1;
    localparam int CUBE = RATIO * RATIO * RATIO;
    // Centering arithmetic width, room for the full offset range
    localparam int CW   = 34;
    localparam int SMAX = 2 ** (`SDP_SAMPLE_W - 1) - 1;
    localparam int SMIN = -(2 ** (`SDP_SAMPLE_W - 1));

    logic [W-1:0] integ1;
    logic [W-1:0] integ2;
    logic [W-1:0] integ3;
    logic [W-1:0] integ3_d;
    logic [W-1:0] comb1;
    logic [W-1:0] comb1_d;
    logic [W-1:0] comb2;
    logic [W-1:0] comb2_d;
    logic [W-1:0] comb3;

    logic signed [CW-1:0] raw_ext;
    logic signed [CW-1:0] offset_ext;
    logic signed [CW-1:0] centered;

    ////////////////////////////////////////////////////////////////////////////
    // Integrators at the bit rate, wrapping

    always_ff @(posedge clock) begin
        if (rst) begin
            integ1 <= '0;
            integ2 <= '0;
            integ3 <= '0;
        end else if (bit_strobe) begin
            integ1 <= integ1 + W'(bit_in);
            integ2 <= integ2 + integ1;
            integ3 <= integ3 + integ2;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Combs at the decimated rate

    // Differences against the previous decimation point
    assign comb1 = integ3 - integ3_d;
    assign comb2 = comb1 - comb1_d;
    assign comb3 = comb2 - comb2_d;

    always_ff @(posedge clock) begin
        if (rst) begin
            integ3_d <= '0;
            comb1_d  <= '0;
            comb2_d  <= '0;
        end else if (dec_strobe) begin
            integ3_d <= integ3;
            comb1_d  <= comb1;
            comb2_d  <= comb2;
        end
    end

    // Raw value is unsigned, 0 to R^3
    assign raw_ext    = CW'($signed({1'b0, comb3}));
    assign offset_ext = CW'(offset);
    assign centered   = raw_ext - CW'(CUBE / 2) - offset_ext;

    // Saturate and register the result
    always_ff @(posedge clock) begin
        if (dec_strobe) begin
            if (centered > CW'(SMAX)) begin
                sample <= `SDP_SAMPLE_W'(SMAX);
            end else if (centered < CW'(SMIN)) begin
                sample <= `SDP_SAMPLE_W'(SMIN);
            end else begin
                sample <= centered[`SDP_SAMPLE_W-1:0];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= dec_strobe;
        end
    end

endmodule

/* hdl/sd_clock_gen.sv */
/*
 Modulator clock generator
 Bit sampling strobe and both decimation strobes
*/
`include "sdp_macros.svh"

module sd_clock_gen (
    input  logic clock,
    input  logic rst,
    input  logic sync,
    output logic clock_out,
    output logic bit_strobe,
    output logic main_strobe,
    output logic cmp_strobe
);

    localparam int DIV_W  = $clog2(`SDP_SD_DIV);
    localparam int MAIN_W = $clog2(`SDP_MAIN_RATIO);
    localparam int CMP_W  = $clog2(`SDP_CMP_RATIO);

    logic [DIV_W-1:0]  div;
    logic [MAIN_W-1:0] main_cnt;
    logic [CMP_W-1:0]  cmp_cnt;

    // Modulator clock divider, second half of the count is the high phase
    always_ff @(posedge clock) begin
        if (rst) begin
            div <= '0;
        end else if (div == DIV_W'(`SDP_SD_DIV - 1)) begin
            div <= '0;
        end else begin
            div <= div + 1'b1;
        end
    end

    assign clock_out  = (div >= DIV_W'(`SDP_SD_DIV / 2));
    // First cycle of the high phase
    assign bit_strobe = (div == DIV_W'(`SDP_SD_DIV / 2));

    // Decimation points on the last bit of each block
    assign main_strobe = bit_strobe && (main_cnt == MAIN_W'(`SDP_MAIN_RATIO - 1));
    assign cmp_strobe  = bit_strobe && (cmp_cnt == CMP_W'(`SDP_CMP_RATIO - 1));

    // Main bit counter, realigned by sync
    always_ff @(posedge clock) begin
        if (rst || sync) begin
            main_cnt <= '0;
        end else if (main_strobe) begin
            main_cnt <= '0;
        end else if (bit_strobe) begin
            main_cnt <= main_cnt + 1'b1;
        end
    end

    // Comparator bit counter, free running
    always_ff @(posedge clock) begin
        if (rst) begin
            cmp_cnt <= '0;
        end else if (cmp_strobe) begin
            cmp_cnt <= '0;
        end else if (bit_strobe) begin
            cmp_cnt <= cmp_cnt + 1'b1;
        end
    end

endmodule

/* hdl/sdp_pkg.sv */
/*
 Shared types of the sigma-delta front end
 Tagged output sample, register write bundle, per-channel fault mask
*/
`include "sdp_macros.svh"

package sdp_pkg;

    // Channel tag width, at least one bit
    localparam int CH_W = (`SDP_N_CHANNELS > 1) ? $clog2(`SDP_N_CHANNELS) : 1;

    // Register data word width
    localparam int REG_DATA_W = 32;

    // One tagged sample of the output stream
    typedef struct packed {
        logic [CH_W-1:0]                 channel;
        logic signed [`SDP_SAMPLE_W-1:0] data;
    } sample_t;

    // Register write, taken when strobe is high
    typedef struct packed {
        logic                         strobe;
        logic [`SDP_REG_ADDR_W-1:0]   addr;
        logic signed [REG_DATA_W-1:0] data;
    } reg_write_t;

    // One flag per channel
    typedef logic [`SDP_N_CHANNELS-1:0] channel_mask_t;

endpackage

/* include/sdp_macros.svh */
/*
 Build-time constants of the sigma-delta front end
 Channel count, modulator clock divider, decimation ratios, widths
*/
`ifndef SDP_MACROS_SVH
`define SDP_MACROS_SVH

// Number of modulator channels
`define SDP_N_CHANNELS 2

// System clock cycles per modulator clock period
`define SDP_SD_DIV 4

// Main decimation ratio, feeds the output stream
`define SDP_MAIN_RATIO 16

// Fast decimation ratio for the fault comparators
`define SDP_CMP_RATIO 8

// Output sample width, signed
`define SDP_SAMPLE_W 16

// Register file address width
`define SDP_REG_ADDR_W 8

`endif
